//--- include/rx_capture_consts.svh
`ifndef RX_CAPTURE_CONSTS_SVH
`define RX_CAPTURE_CONSTS_SVH

////////////////////////////////////////
// Horizontal capture window
////////////////////////////////////////

// First and last hcount that go into the pixel stream
`define HCAP_FIRST 221
`define HCAP_LAST 1420

////////////////////////////////////////
// Data island framing
////////////////////////////////////////

`define PKT_CLOCKS 32 // One packet, header plus body

////////////////////////////////////////
// Position report characters
////////////////////////////////////////

`define ASCII_CR 13
`define ASCII_LF 10
`define ASCII_ZERO 48
`define ASCII_A 65

`define RPT_DIGITS 4 // Hex digits per 16-bit position

`endif

//--- design/rx_capture_pkg.sv
`default_nettype none

package rx_capture_pkg;

	////////////////////////////////////////
	// Plain vector types
	////////////////////////////////////////

	typedef logic [10:0] count_t;   // Horizontal or vertical count
	typedef logic [11:0] line_t;    // Line or index as stored in a word
	typedef logic [15:0] pos_t;     // Blanking clocks since vde fell
	typedef logic [3:0]  pkt_cnt_t; // Packets per line
	typedef logic [7:0]  chan_t;
	typedef logic [3:0]  nib_t;
	typedef logic [7:0]  byte_t;

	////////////////////////////////////////
	// Grouped signals
	////////////////////////////////////////

	typedef struct packed {
		chan_t red;
		chan_t green;
		chan_t blue;
	} rgb_t;

	typedef struct packed {
		nib_t aux2;
		nib_t aux1;
		nib_t aux0;
	} aux_in_t;

	// Pixel word sent to the Ethernet side, 48 bits
	typedef struct packed {
		line_t line;
		line_t index;
		rgb_t  rgb;
	} pix_word_t;

	// Aux word, position stamp plus the useful nibble bits
	typedef struct packed {
		pos_t pos;
		nib_t aux2;
		nib_t aux1;
		logic aux0_b2;
	} aux_word_t;

	typedef enum logic [1:0] {
		RPT_IDLE,
		RPT_DIGIT,
		RPT_CR,
		RPT_LF
	} rpt_state_t;

endpackage

`default_nettype wire

//--- design/rx_line_timing.sv
`default_nettype none

module rx_line_timing (
	input  wire                    rx0_pclk,
	input  wire                    RSTBTN,
	input  wire                    hsync,
	input  wire                    vsync,
	input  wire                    vde,
	output rx_capture_pkg::count_t hcount,
	output rx_capture_pkg::count_t vcount,
	output logic                   hsync_rise,
	output logic                   armed
);

	import rx_capture_pkg::*;

	localparam count_t COUNT_MAX = '1;

	logic hsync_q;
	logic vsync_q;
	logic h_edge;
	logic v_edge;

	assign h_edge = hsync & ~hsync_q;
	assign v_edge = vsync & ~vsync_q;

	////////////////////////////////////////
	// Sync edge detection
	////////////////////////////////////////

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			hsync_q    <= 1'b0;
			vsync_q    <= 1'b0;
			hsync_rise <= 1'b0;
		end else begin
			hsync_q    <= hsync;
			vsync_q    <= vsync;
			hsync_rise <= h_edge; // Lines up with hcount == 0
		end
	end

	////////////////////////////////////////
	// Position counters
	////////////////////////////////////////

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			hcount <= '0;
			vcount <= '0;
		end else begin
			if (h_edge)
				hcount <= '0;
			else
				hcount <= hcount + 1'b1;

			// Frame start wins over line start
			if (v_edge)
				vcount <= '0;
			else if (h_edge)
				vcount <= vcount + 1'b1;
		end
	end

	// Aux capture waits for the first active video after reset
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			armed <= 1'b0;
		else if (vde)
			armed <= 1'b1;
	end

	// hcount may only come back to zero through a sync edge
	a_hcount_no_wrap: assert property (
		@(posedge rx0_pclk) disable iff (RSTBTN)
		(hcount == COUNT_MAX) |=> hsync_rise
	);

endmodule

`default_nettype wire

//--- design/pixel_capture.sv
`default_nettype none

`include "rx_capture_consts.svh"

module pixel_capture (
	input  wire                         rx0_pclk,
	input  wire                         RSTBTN,
	input  wire                         vde,
	input  wire rx_capture_pkg::rgb_t   rgb,
	input  wire rx_capture_pkg::count_t hcount,
	input  wire rx_capture_pkg::count_t vcount,
	input  wire                         hsync_rise,
	output logic                        pix_valid,
	output rx_capture_pkg::pix_word_t   pix_word
);

	import rx_capture_pkg::*;

	localparam count_t WIN_FIRST = count_t'(`HCAP_FIRST);
	localparam count_t WIN_LAST  = count_t'(`HCAP_LAST);

	logic  in_win;
	line_t pix_idx; // Position inside the captured part of the line

	assign in_win = vde && (hcount >= WIN_FIRST) && (hcount <= WIN_LAST);

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			pix_idx <= '0;
		else if (hsync_rise)
			pix_idx <= '0;
		else if (in_win)
			pix_idx <= pix_idx + 1'b1;
	end

	////////////////////////////////////////
	// Output word register
	////////////////////////////////////////

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			pix_valid <= 1'b0;
		else
			pix_valid <= in_win;
	end

	always_ff @(posedge rx0_pclk) begin
		pix_word.line  <= line_t'(vcount); // Zero extended to 12 bits
		pix_word.index <= pix_idx;
		pix_word.rgb   <= rgb;
	end

	// A strobe always comes from active video one cycle back
	a_valid_needs_vde: assert property (
		@(posedge rx0_pclk) disable iff (RSTBTN)
		pix_valid |-> $past(vde)
	);

endmodule

`default_nettype wire

//--- design/data_island_tracker.sv
`default_nettype none

`include "rx_capture_consts.svh"

module data_island_tracker (
	input  wire                          rx0_pclk,
	input  wire                          RSTBTN,
	input  wire                          vde,
	input  wire                          ade,
	input  wire rx_capture_pkg::aux_in_t aux,
	input  wire                          armed,
	output logic                         pkt_start,
	output rx_capture_pkg::pos_t         pos,
	output logic                         aux_valid,
	output rx_capture_pkg::aux_word_t    aux_word,
	output rx_capture_pkg::pkt_cnt_t     ade_num
);

	import rx_capture_pkg::*;

	localparam int PKT_W = $clog2(`PKT_CLOCKS);
	localparam logic [PKT_W-1:0] PKT_LAST = PKT_W'(`PKT_CLOCKS - 1);

	logic             vde_q;
	logic             vde_rise;
	logic [PKT_W-1:0] pkt_clk;   // Clock within the current packet
	pkt_cnt_t         pkt_count; // Packets since last vde rise

	assign vde_rise  = vde & ~vde_q;
	assign pkt_start = ade && (pkt_clk == '0);

	////////////////////////////////////////
	// Blanking position
	////////////////////////////////////////

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			vde_q <= 1'b0;
			pos   <= '0;
		end else begin
			vde_q <= vde;
			if (vde)
				pos <= '0;
			else
				pos <= pos + 1'b1;
		end
	end

	////////////////////////////////////////
	// Packet framing
	////////////////////////////////////////

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			pkt_clk <= '0;
		else if (!ade)
			pkt_clk <= '0;
		else if (pkt_clk == PKT_LAST)
			pkt_clk <= '0;
		else
			pkt_clk <= pkt_clk + 1'b1;
	end

	// Count for the line is handed over when video resumes
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			pkt_count <= '0;
			ade_num   <= '0;
		end else if (vde_rise) begin
			ade_num   <= pkt_count;
			pkt_count <= pkt_start ? pkt_cnt_t'(1) : '0;
		end else if (pkt_start) begin
			pkt_count <= pkt_count + 1'b1;
		end
	end

	////////////////////////////////////////
	// Aux word capture
	////////////////////////////////////////

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			aux_valid <= 1'b0;
		else
			aux_valid <= ade & armed;
	end

	always_ff @(posedge rx0_pclk) begin
		aux_word.pos     <= pos;
		aux_word.aux2    <= aux.aux2;
		aux_word.aux1    <= aux.aux1;
		aux_word.aux0_b2 <= aux.aux0[2]; // Only bit 2 carries packet data
	end

	// Mid-packet count only follows an ade clock
	a_pkt_clk_range: assert property (
		@(posedge rx0_pclk) disable iff (RSTBTN)
		(pkt_clk != '0) |-> ($past(ade) && (pkt_clk < `PKT_CLOCKS))
	);

endmodule

`default_nettype wire

//--- design/pos_reporter.sv
`default_nettype none

`include "rx_capture_consts.svh"

module pos_reporter (
	input  wire                       rx0_pclk,
	input  wire                       RSTBTN,
	input  wire                       pkt_start,
	input  wire rx_capture_pkg::pos_t pos,
	output logic                      byte_valid,
	output rx_capture_pkg::byte_t     byte_data
);

	import rx_capture_pkg::*;

	localparam int DIG_W = $clog2(`RPT_DIGITS + 1);
	localparam logic [DIG_W-1:0] DIG_LAST = DIG_W'(`RPT_DIGITS);

	rpt_state_t       state;
	logic [DIG_W-1:0] dig_cnt; // Digits already sent
	pos_t             shift;   // Remaining nibbles, top first

	// Upper case hex digit
	function automatic byte_t hex_char(input nib_t nib);
		byte_t ch;
		if (nib < 4'd10)
			ch = byte_t'(`ASCII_ZERO) + byte_t'(nib);
		else
			ch = byte_t'(`ASCII_A) + byte_t'(nib) - byte_t'(10);
		return ch;
	endfunction

	////////////////////////////////////////
	// Report FSM
	////////////////////////////////////////

	// state names the byte currently on byte_data
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			state      <= RPT_IDLE;
			dig_cnt    <= '0;
			byte_valid <= 1'b0;
		end else begin
			case (state)
				RPT_IDLE: begin
					byte_valid <= 1'b0;
					if (pkt_start) begin
						byte_valid <= 1'b1;
						dig_cnt    <= DIG_W'(1);
						state      <= RPT_DIGIT;
					end
				end
				RPT_DIGIT: begin
					byte_valid <= 1'b1;
					if (dig_cnt == DIG_LAST)
						state <= RPT_CR;
					else
						dig_cnt <= dig_cnt + 1'b1;
				end
				RPT_CR: begin
					byte_valid <= 1'b1;
					state      <= RPT_LF;
				end
				default: begin // RPT_LF, last byte out
					byte_valid <= 1'b0;
					state      <= RPT_IDLE;
				end
			endcase
		end
	end

	// Datapath, follows the FSM decisions above
	always_ff @(posedge rx0_pclk) begin
		case (state)
			RPT_IDLE: begin
				byte_data <= hex_char(pos[15:12]);
				shift     <= pos << 4; // Latch position
			end
			RPT_DIGIT: begin
				if (dig_cnt == DIG_LAST) begin
					byte_data <= byte_t'(`ASCII_CR);
				end else begin
					byte_data <= hex_char(shift[15:12]);
					shift     <= shift << 4;
				end
			end
			RPT_CR:  byte_data <= byte_t'(`ASCII_LF);
			default: byte_data <= byte_data;
		endcase
	end

	a_idle_quiet: assert property (
		@(posedge rx0_pclk) disable iff (RSTBTN)
		(state == RPT_IDLE) |-> !byte_valid
	);

endmodule

`default_nettype wire

//--- design/rx_capture_top.sv
`default_nettype none

module rx_capture_top (
	input  wire                          rx0_pclk,
	input  wire                          RSTBTN,
	input  wire                          hsync,
	input  wire                          vsync,
	input  wire                          vde,
	input  wire                          ade,
	input  wire rx_capture_pkg::rgb_t    rgb,
	input  wire rx_capture_pkg::aux_in_t aux,
	output wire                          pix_valid,
	output wire rx_capture_pkg::pix_word_t pix_word,
	output wire                          aux_valid,
	output wire rx_capture_pkg::aux_word_t aux_word,
	output wire rx_capture_pkg::pkt_cnt_t  ade_num,
	output wire                          byte_valid,
	output wire rx_capture_pkg::byte_t   byte_data
);

	import rx_capture_pkg::*;

	count_t hcount;
	count_t vcount;
	logic   hsync_rise;
	logic   armed;
	logic   pkt_start;
	pos_t   pos;

	////////////////////////////////////////
	// Line and frame position
	////////////////////////////////////////

	rx_line_timing u_timing (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.hsync      (hsync),
		.vsync      (vsync),
		.vde        (vde),
		.hcount     (hcount),
		.vcount     (vcount),
		.hsync_rise (hsync_rise),
		.armed      (armed)
	);

	pixel_capture u_pixel (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.vde        (vde),
		.rgb        (rgb),
		.hcount     (hcount),
		.vcount     (vcount),
		.hsync_rise (hsync_rise),
		.pix_valid  (pix_valid),  // Pixel FIFO write enable
		.pix_word   (pix_word)
	);

	////////////////////////////////////////
	// Data islands
	////////////////////////////////////////

	data_island_tracker u_island (
		.rx0_pclk  (rx0_pclk),
		.RSTBTN    (RSTBTN),
		.vde       (vde),
		.ade       (ade),
		.aux       (aux),
		.armed     (armed),
		.pkt_start (pkt_start),
		.pos       (pos),
		.aux_valid (aux_valid), // Aux FIFO write enable
		.aux_word  (aux_word),
		.ade_num   (ade_num)
	);

	pos_reporter u_report (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.pkt_start  (pkt_start),
		.pos        (pos),
		.byte_valid (byte_valid),
		.byte_data  (byte_data)
	);

endmodule

`default_nettype wire

//--- tb/tb_rx_capture.sv
`default_nettype none

`include "rx_capture_consts.svh"

module tb_rx_capture;

	import rx_capture_pkg::*;

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 16;
	localparam int FRAMES       = 3;
	localparam int LINES        = 4;
	localparam int LINE_CLOCKS  = 1500;
	localparam int TAIL_CLOCKS  = 8;
	localparam int MAX_CYCLES   = FRAMES * LINES * LINE_CLOCKS + 2000; // Plus margin
	localparam int BURST_FIRST  = 40; // Earliest line position of the first ade clock
	localparam int LINE_PIXELS  = `HCAP_LAST - `HCAP_FIRST + 1;

	logic      rx0_pclk;
	logic      RSTBTN;
	logic      hsync;
	logic      vsync;
	logic      vde;
	logic      ade;
	rgb_t      rgb;
	aux_in_t   aux;
	logic      pix_valid;
	pix_word_t pix_word;
	logic      aux_valid;
	aux_word_t aux_word;
	pkt_cnt_t  ade_num;
	logic      byte_valid;
	byte_t     byte_data;

	// Reference model registers
	count_t    m_h;
	count_t    m_v;
	line_t     m_idx;
	pos_t      m_pos;
	logic      m_armed;
	logic      m_hs_q;
	logic      m_vs_q;
	logic      m_de_q;

	// Outputs expected at the next falling edge
	logic      exp_pv;
	pix_word_t exp_pix;
	logic      exp_av;
	aux_word_t exp_aux;
	pkt_cnt_t  exp_ade_num;
	byte_t     byte_q[$];

	logic        rep_active; // Reporter sending a byte this cycle
	int          line_pix;
	int          cycles = 0;
	logic [31:0] lfsr;

	rx_capture_top DUT (
		.rx0_pclk   (rx0_pclk),
		.RSTBTN     (RSTBTN),
		.hsync      (hsync),
		.vsync      (vsync),
		.vde        (vde),
		.ade        (ade),
		.rgb        (rgb),
		.aux        (aux),
		.pix_valid  (pix_valid),
		.pix_word   (pix_word),
		.aux_valid  (aux_valid),
		.aux_word   (aux_word),
		.ade_num    (ade_num),
		.byte_valid (byte_valid),
		.byte_data  (byte_data)
	);

	initial begin
		rx0_pclk = 1'b0;
		forever #(HALF_PERIOD) rx0_pclk = ~rx0_pclk;
	end

	always @(posedge rx0_pclk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			stop_run();
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic stop_run();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] got_v);
		$display("Error: %s expected 0x%0h got 0x%0h", name, exp_v, got_v);
		stop_run();
	endtask

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic byte_t hex_ascii(input logic [3:0] n);
		if (n < 4'd10)
			return byte_t'(`ASCII_ZERO + n);
		return byte_t'(`ASCII_A + n - 10);
	endfunction

	////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////

	task automatic drive_and_predict(input int p, input int line_no, input int n_bursts,
			input int burst_first);
		logic        hs_v;
		logic        vs_v;
		logic        de_v;
		logic        in_burst;
		logic        burst_start;
		logic        h_edge;
		logic        v_edge;
		logic [31:0] r;
		rgb_t        rgb_v;
		aux_in_t     aux_v;

		hs_v = (p < 10);
		vs_v = (p < 10) && (line_no == 0); // Frame start
		de_v = (m_h >= 200) && (m_h <= 1450);
		in_burst = (p >= burst_first) && (p < burst_first + n_bursts * `PKT_CLOCKS);
		burst_start = in_burst && ((p - burst_first) % `PKT_CLOCKS == 0);
		rgb_v = '0;
		aux_v = '0;
		if (de_v) begin
			take_bits(24, r);
			rgb_v = rgb_t'(r[23:0]);
		end
		if (in_burst) begin
			take_bits(12, r);
			aux_v = aux_in_t'(r[11:0]);
		end
		hsync = hs_v;
		vsync = vs_v;
		vde   = de_v;
		ade   = in_burst;
		rgb   = rgb_v;
		aux   = aux_v;

		exp_pv = de_v && (m_h >= `HCAP_FIRST) && (m_h <= `HCAP_LAST);
		if (exp_pv) begin
			exp_pix.line  = line_t'(m_v);
			exp_pix.index = m_idx;
			exp_pix.rgb   = rgb_v;
			m_idx = m_idx + 1'b1;
		end
		exp_av = in_burst && m_armed; // Nothing before the first vde
		if (exp_av) begin
			exp_aux.pos     = m_pos;
			exp_aux.aux2    = aux_v.aux2;
			exp_aux.aux1    = aux_v.aux1;
			exp_aux.aux0_b2 = aux_v.aux0[2];
		end
		if (burst_start && !rep_active) begin
			for (int i = 0; i < `RPT_DIGITS; i++)
				byte_q.push_back(hex_ascii(m_pos[15 - 4 * i -: 4]));
			byte_q.push_back(byte_t'(`ASCII_CR));
			byte_q.push_back(byte_t'(`ASCII_LF));
		end
		if (de_v && !m_de_q)
			exp_ade_num = pkt_cnt_t'(n_bursts);

		h_edge = hs_v && !m_hs_q;
		v_edge = vs_v && !m_vs_q;
		m_h = h_edge ? count_t'(0) : m_h + 1'b1;
		if (v_edge)
			m_v = '0;
		else if (h_edge)
			m_v = m_v + 1'b1;
		if (h_edge)
			m_idx = '0;
		m_pos   = de_v ? pos_t'(0) : m_pos + 1'b1;
		m_armed = m_armed | de_v;
		m_hs_q  = hs_v;
		m_vs_q  = vs_v;
		m_de_q  = de_v;
	endtask

	// Outputs are stable half a clock after the rising edge
	task automatic check_outputs();
		byte_t exp_b;

		assert (pix_valid === exp_pv)
			else report_mismatch("pix_valid", exp_pv, pix_valid);
		if (exp_pv)
			assert (pix_word === exp_pix)
				else report_mismatch("pix_word", exp_pix, pix_word);
		if (pix_valid === 1'b1)
			line_pix = line_pix + 1;
		assert (aux_valid === exp_av)
			else report_mismatch("aux_valid", exp_av, aux_valid);
		if (exp_av)
			assert (aux_word === exp_aux)
				else report_mismatch("aux_word", exp_aux, aux_word);
		assert (ade_num === exp_ade_num)
			else report_mismatch("ade_num", exp_ade_num, ade_num);
		rep_active = (byte_q.size() > 0);
		if (rep_active) begin
			exp_b = byte_q.pop_front();
			assert (byte_valid === 1'b1)
				else report_mismatch("byte_valid", 1'b1, byte_valid);
			assert (byte_data === exp_b)
				else report_mismatch("byte_data", exp_b, byte_data);
		end else begin
			assert (byte_valid === 1'b0)
				else report_mismatch("byte_valid", 1'b0, byte_valid);
		end
	endtask

	task automatic check_line_pixels();
		assert (line_pix == LINE_PIXELS)
			else report_mismatch("pix_valid count per line", LINE_PIXELS, line_pix);
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		logic [31:0] r;
		int          n_bursts;
		int          burst_first;

		RSTBTN = 1'b1;
		hsync  = 1'b0;
		vsync  = 1'b0;
		vde    = 1'b0;
		ade    = 1'b0;
		rgb    = '0;
		aux    = '0;
		lfsr   = 32'he63b_3784;
		m_h     = '0;
		m_v     = '0;
		m_idx   = '0;
		m_pos   = '0;
		m_armed = 1'b0;
		m_hs_q  = 1'b0;
		m_vs_q  = 1'b0;
		m_de_q  = 1'b0;
		exp_pv      = 1'b0;
		exp_pix     = '0;
		exp_av      = 1'b0;
		exp_aux     = '0;
		exp_ade_num = '0;
		rep_active  = 1'b0;
		line_pix    = 0;

		// Strobes and ade_num must read zero throughout reset
		repeat (RESET_CYCLES) begin
			@(negedge rx0_pclk);
			check_outputs();
		end
		RSTBTN = 1'b0;

		for (int f = 0; f < FRAMES; f++) begin
			for (int l = 0; l < LINES; l++) begin
				if (f > 0 || l > 0)
					check_line_pixels();
				line_pix = 0;
				take_bits(1, r);
				n_bursts = 1 + int'(r[0]); // One or two packets per blanking
				// Later bursts start later so the reported low digit runs through A to F
				burst_first = BURST_FIRST + f * LINES + l;
				for (int p = 0; p < LINE_CLOCKS; p++) begin
					drive_and_predict(p, l, n_bursts, burst_first);
					@(negedge rx0_pclk);
					check_outputs();
				end
			end
		end

		// Idle clocks so the last strobes drain
		for (int p = LINE_CLOCKS; p < LINE_CLOCKS + TAIL_CLOCKS; p++) begin
			drive_and_predict(p, 1, 0, BURST_FIRST);
			@(negedge rx0_pclk);
			check_outputs();
		end
		check_line_pixels();

		if (byte_q.size() != 0) begin
			$display("Position report ended with %0d bytes never sent", byte_q.size());
			stop_run();
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
design/rx_capture_pkg.sv
design/rx_line_timing.sv
design/pixel_capture.sv
design/data_island_tracker.sv
design/pos_reporter.sv
design/rx_capture_top.sv
tb/tb_rx_capture.sv
